// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_rs
FLIST     = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

SRCS = $(shell grep -v '^+' $(FLIST)) rs_settings.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rs_entry.sv ====
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_entry (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 e_alloc,
    input  rs_pkg::t_uinstr_disp q_alloc_static,
    input  logic                 ro_valid,
    input  rs_pkg::t_rob_result  ro_result,
    input  logic                 e_gnt_issue,
    output logic                 e_valid,
    output logic                 e_req_issue,
    output rs_pkg::t_uinstr_iss  e_issue_pkt
);

    localparam int SRC1 = 0;
    localparam int SRC2 = 1;

    typedef enum logic {
        IDLE,
        VALID
    } t_ent_state;

    t_ent_state state;
    t_ent_state state_nxt;

    logic [7:0]     opcode_q;
    rs_pkg::t_robid robid_q;

    rs_pkg::t_rs_reg_trk_static   trk_static [`RS_NUM_SOURCES];
    rs_pkg::t_rv_reg_data         src_data   [`RS_NUM_SOURCES];
    logic [`RS_NUM_SOURCES-1:0]   src_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (e_alloc) begin
                    state_nxt = VALID;
                end
            end
            VALID: begin
                // Leaves on issue, no replay
                if (e_gnt_issue) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign e_valid = (state == VALID);

    // Fields that only ride along to the issue packet
    always_ff @(posedge clk) begin
        if (e_alloc) begin
            opcode_q <= q_alloc_static.opcode;
            robid_q  <= q_alloc_static.robid;
        end
    end

    assign trk_static[SRC1].from_rob = q_alloc_static.src1_rob_pdg;
    assign trk_static[SRC1].word     = q_alloc_static.src1;
    assign trk_static[SRC2].from_rob = q_alloc_static.src2_rob_pdg;
    assign trk_static[SRC2].word     = q_alloc_static.src2;

    for (genvar s = 0; s < `RS_NUM_SOURCES; s++) begin : g_src_trk
        rs_reg_trk u_trk (
            .clk            (clk),
            .reset          (reset),
            .e_alloc        (e_alloc),
            .e_alloc_static (trk_static[s]),
            .ro_valid       (ro_valid),
            .ro_result      (ro_result),
            .ready          (src_ready[s]),
            .src_data       (src_data[s])
        );
    end

    assign e_req_issue = e_valid & (&src_ready);

    always_comb begin
        e_issue_pkt.opcode   = opcode_q;
        e_issue_pkt.robid    = robid_q;
        e_issue_pkt.src1_val = src_data[SRC1];
        e_issue_pkt.src2_val = src_data[SRC2];
    end

    a_no_alloc_valid: assert property (
        @(posedge clk) disable iff (reset) e_alloc |-> !e_valid
    ) else $error("rs_entry: allocated while valid");

    a_gnt_has_req: assert property (
        @(posedge clk) disable iff (reset) e_gnt_issue |-> e_req_issue
    ) else $error("rs_entry: grant without request");

endmodule

// ==== rs_pkg.sv ====
`include "rs_settings.svh"

package rs_pkg;

    typedef logic [`RS_XLEN-1:0] t_rv_reg_data;
    typedef logic [`RS_ROBID_W-1:0] t_robid;

    // Pending form of an operand word, tag in the low bits
    typedef struct packed {
        logic [`RS_XLEN-`RS_ROBID_W-1:0] pad;
        t_robid                          robid;
    } t_src_tag;

    // Read as a value when ready, as a producer tag when pending
    typedef union packed {
        t_rv_reg_data value;
        t_src_tag     tag;
    } t_src_word;

    typedef struct packed {
        logic [7:0] opcode;
        t_robid     robid;
        logic       src1_rob_pdg;
        t_src_word  src1;
        logic       src2_rob_pdg;
        t_src_word  src2;
    } t_uinstr_disp;

    typedef struct packed {
        logic      from_rob;
        t_src_word word;
    } t_rs_reg_trk_static;

    // One ROB result broadcast
    typedef struct packed {
        t_robid       robid;
        t_rv_reg_data data;
    } t_rob_result;

    typedef struct packed {
        logic [7:0]   opcode;
        t_robid       robid;
        t_rv_reg_data src1_val;
        t_rv_reg_data src2_val;
    } t_uinstr_iss;

endpackage

// ==== rs_reg_trk.sv ====
`timescale 1ns/1ps

module rs_reg_trk (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       e_alloc,
    input  rs_pkg::t_rs_reg_trk_static e_alloc_static,
    input  logic                       ro_valid,
    input  rs_pkg::t_rob_result        ro_result,
    output logic                       ready,
    output rs_pkg::t_rv_reg_data       src_data
);

    rs_pkg::t_robid wait_robid;
    logic           alloc_hit;
    logic           wait_hit;

    // Producer broadcasting in the same cycle as the allocation
    assign alloc_hit = e_alloc_static.from_rob & ro_valid &
                       (ro_result.robid == e_alloc_static.word.tag.robid);

    // Later broadcast for the tag we hold
    assign wait_hit = ~ready & ro_valid & (ro_result.robid == wait_robid);

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= 1'b0;
        end else if (e_alloc) begin
            ready <= ~e_alloc_static.from_rob | alloc_hit;
        end else if (wait_hit) begin
            ready <= 1'b1;
        end
    end

    // Operand value, and the tag while waiting
    always_ff @(posedge clk) begin
        if (e_alloc) begin
            wait_robid <= e_alloc_static.word.tag.robid;
            if (!e_alloc_static.from_rob) begin
                src_data <= e_alloc_static.word.value;
            end else if (alloc_hit) begin
                src_data <= ro_result.data;
            end
        end else if (wait_hit) begin
            src_data <= ro_result.data;
        end
    end

endmodule

// ==== rs_select.sv ====
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_select (
    input  logic [`RS_NUM_ENTRIES-1:0] e_valid,
    input  logic [`RS_NUM_ENTRIES-1:0] e_req_issue,
    output logic [`RS_NUM_ENTRIES-1:0] alloc_sel,
    output logic [`RS_NUM_ENTRIES-1:0] gnt,
    output logic                       full
);

    // One-hot of the lowest set bit, zero when none is set
    function automatic logic [`RS_NUM_ENTRIES-1:0] lowest_one(
        input logic [`RS_NUM_ENTRIES-1:0] vec
    );
        logic [`RS_NUM_ENTRIES-1:0] sel;
        logic                       found;
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
            if (vec[i] && !found) begin
                sel[i] = 1'b1;
                found  = 1'b1;
            end
        end
        return sel;
    endfunction

    // Lowest idle entry takes the next dispatch
    assign alloc_sel = lowest_one(~e_valid);

    // Lowest requesting entry issues
    assign gnt = lowest_one(e_req_issue);

    assign full = &e_valid;

endmodule

// ==== rs_settings.svh ====
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Reservation station sizing
`define RS_NUM_ENTRIES 4

// Operand and ROB tag widths
`define RS_XLEN 32
`define RS_ROBID_W 5

// Source operands per micro-op
`define RS_NUM_SOURCES 2

`endif

// ==== rs_top.sv ====
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 disp_valid,
    input  rs_pkg::t_uinstr_disp disp_uinstr,
    input  logic                 ro_valid,
    input  rs_pkg::t_rob_result  ro_result,
    output logic                 full,
    output logic                 iss_valid,
    output rs_pkg::t_uinstr_iss  iss_pkt
);

    logic [`RS_NUM_ENTRIES-1:0] e_valid;
    logic [`RS_NUM_ENTRIES-1:0] e_req_issue;
    logic [`RS_NUM_ENTRIES-1:0] alloc_sel;
    logic [`RS_NUM_ENTRIES-1:0] e_alloc;
    logic [`RS_NUM_ENTRIES-1:0] gnt;

    rs_pkg::t_uinstr_iss e_issue_pkt [`RS_NUM_ENTRIES];
    rs_pkg::t_uinstr_iss gnt_pkt;

    assign e_alloc = alloc_sel & {`RS_NUM_ENTRIES{disp_valid}};

    for (genvar e = 0; e < `RS_NUM_ENTRIES; e++) begin : g_entry
        rs_entry u_entry (
            .clk            (clk),
            .reset          (reset),
            .e_alloc        (e_alloc[e]),
            .q_alloc_static (disp_uinstr),
            .ro_valid       (ro_valid),
            .ro_result      (ro_result),
            .e_gnt_issue    (gnt[e]),
            .e_valid        (e_valid[e]),
            .e_req_issue    (e_req_issue[e]),
            .e_issue_pkt    (e_issue_pkt[e])
        );
    end

    rs_select u_select (
        .e_valid     (e_valid),
        .e_req_issue (e_req_issue),
        .alloc_sel   (alloc_sel),
        .gnt         (gnt),
        .full        (full)
    );

    // Grant is one-hot, so a plain pick is enough
    always_comb begin
        gnt_pkt = '0;
        for (int i = 0; i < `RS_NUM_ENTRIES; i++) begin
            if (gnt[i]) begin
                gnt_pkt = e_issue_pkt[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= |gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (|gnt) begin
            iss_pkt <= gnt_pkt;
        end
    end

    // Upstream has to stall on full
    a_no_disp_full: assert property (
        @(posedge clk) disable iff (reset) disp_valid |-> !full
    ) else $error("rs_top: dispatch while full");

endmodule

// ==== sources.f ====
+incdir+.
rs_pkg.sv
rs_reg_trk.sv
rs_entry.sv
rs_select.sv
rs_top.sv
tb_rs.sv

// ==== tb_rs.sv ====
`timescale 1ns/1ps
`include "rs_settings.svh"

module tb_rs;

    localparam int N = `RS_NUM_ENTRIES;
    localparam int CLK_PERIOD = 4;
    localparam int RANDOM_CYC = 2000;
    localparam int DRAIN_CYC = 200;
    // Reset, directed tests with slack, random run, drain
    localparam int TOTAL_CYC = 10 + 120 + RANDOM_CYC + DRAIN_CYC;

    logic                 clk;
    logic                 reset;
    logic                 disp_valid;
    rs_pkg::t_uinstr_disp disp_uinstr;
    logic                 ro_valid;
    rs_pkg::t_rob_result  ro_result;
    logic                 full;
    logic                 iss_valid;
    rs_pkg::t_uinstr_iss  iss_pkt;

    integer         seed;
    int             err_cnt;
    int             check_cnt;
    int             test_err_base;
    int             disp_cnt;
    int             issue_cnt;
    rs_pkg::t_robid next_rob;
    logic           outstanding [2**`RS_ROBID_W];

    // Shadow of the entries
    logic                 m_valid [N];
    logic [7:0]           m_op    [N];
    rs_pkg::t_robid       m_rob   [N];
    logic                 m_rdy   [N][2];
    rs_pkg::t_robid       m_tag   [N][2];
    rs_pkg::t_rv_reg_data m_val   [N][2];
    logic                 exp_iss;
    logic                 exp_full;
    rs_pkg::t_uinstr_iss  exp_pkt;

    rs_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYC * CLK_PERIOD + 100);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYC);
        $display("Errors found");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        err_cnt++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic report_test(input string name);
        $display("test %-12s finished, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    function automatic rs_pkg::t_src_word make_src(input logic pdg, input logic [31:0] w);
        rs_pkg::t_src_word sw;
        sw = '0;
        if (pdg)
            sw.tag.robid = w[`RS_ROBID_W-1:0];
        else
            sw.value = w;
        return sw;
    endfunction

    function automatic logic model_empty();
        logic empty;
        empty = 1'b1;
        for (int i = 0; i < N; i++)
            if (m_valid[i])
                empty = 1'b0;
        return empty;
    endfunction

    // Predicts the next edge from the inputs now driven
    task automatic model_step();
        int                g;
        int                a;
        logic [1:0]        pdg;
        rs_pkg::t_src_word w [2];
        g = -1;
        a = -1;
        for (int i = N - 1; i >= 0; i--) begin
            if (m_valid[i] && m_rdy[i][0] && m_rdy[i][1])
                g = i;
            if (!m_valid[i])
                a = i;
        end
        exp_iss = (g >= 0);
        for (int i = 0; i < N; i++)
            for (int s = 0; s < 2; s++)
                if (m_valid[i] && !m_rdy[i][s] && ro_valid &&
                    ro_result.robid == m_tag[i][s]) begin
                    m_rdy[i][s] = 1'b1;
                    m_val[i][s] = ro_result.data;
                end
        if (g >= 0) begin
            exp_pkt.opcode   = m_op[g];
            exp_pkt.robid    = m_rob[g];
            exp_pkt.src1_val = m_val[g][0];
            exp_pkt.src2_val = m_val[g][1];
            m_valid[g]       = 1'b0;
        end
        if (disp_valid && a >= 0) begin
            w[0]       = disp_uinstr.src1;
            w[1]       = disp_uinstr.src2;
            pdg        = {disp_uinstr.src2_rob_pdg, disp_uinstr.src1_rob_pdg};
            m_valid[a] = 1'b1;
            m_op[a]    = disp_uinstr.opcode;
            m_rob[a]   = disp_uinstr.robid;
            for (int s = 0; s < 2; s++) begin
                // Same-cycle broadcast counts for a pending source
                m_tag[a][s] = w[s].tag.robid;
                m_rdy[a][s] = !pdg[s] || (ro_valid && ro_result.robid == w[s].tag.robid);
                m_val[a][s] = pdg[s] ? ro_result.data : w[s].value;
            end
        end
        exp_full = 1'b1;
        for (int i = 0; i < N; i++)
            exp_full = exp_full & m_valid[i];
    endtask

    task automatic advance();
        model_step();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        ro_valid   = 1'b0;
        check("iss_valid", iss_valid, exp_iss);
        check("full", full, exp_full);
        if (exp_iss && iss_valid) begin
            check("iss_pkt.opcode", iss_pkt.opcode, exp_pkt.opcode);
            check("iss_pkt.robid", iss_pkt.robid, exp_pkt.robid);
            check("iss_pkt.src1_val", iss_pkt.src1_val, exp_pkt.src1_val);
            check("iss_pkt.src2_val", iss_pkt.src2_val, exp_pkt.src2_val);
        end
        if (iss_valid)
            issue_cnt++;
    endtask

    task automatic set_disp(input logic [7:0] op, input logic p1, input logic [31:0] w1,
                            input logic p2, input logic [31:0] w2);
        disp_valid               = 1'b1;
        disp_uinstr.opcode       = op;
        disp_uinstr.robid        = next_rob;
        disp_uinstr.src1_rob_pdg = p1;
        disp_uinstr.src1         = make_src(p1, w1);
        disp_uinstr.src2_rob_pdg = p2;
        disp_uinstr.src2         = make_src(p2, w2);
        if (p1)
            outstanding[w1[`RS_ROBID_W-1:0]] = 1'b1;
        if (p2)
            outstanding[w2[`RS_ROBID_W-1:0]] = 1'b1;
        next_rob++;
        disp_cnt++;
    endtask

    task automatic set_bcast(input rs_pkg::t_robid tag, input logic [31:0] data);
        ro_valid         = 1'b1;
        ro_result.robid  = tag;
        ro_result.data   = data;
        outstanding[tag] = 1'b0;
    endtask

    // Counts the trigger cycle as the first one
    task automatic wait_issue(output int lat);
        lat = 1;
        while (!iss_valid && lat < 16) begin
            advance();
            lat++;
        end
        if (!iss_valid)
            report_failure("No issue seen within 16 cycles of the trigger");
    endtask

    initial begin : main
        logic [31:0]    rnd;
        logic [31:0]    w [2];
        rs_pkg::t_robid first_rob;
        int             lat;
        int             guard;
        seed = 32'h8652;
        err_cnt       = 0;
        check_cnt     = 0;
        test_err_base = 0;
        disp_cnt      = 0;
        issue_cnt     = 0;
        next_rob    = '0;
        disp_valid  = 1'b0;
        disp_uinstr = '0;
        ro_valid    = 1'b0;
        ro_result   = '0;
        for (int i = 0; i < N; i++)
            m_valid[i] = 1'b0;
        for (int t = 0; t < 2**`RS_ROBID_W; t++)
            outstanding[t] = 1'b0;
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check("iss_valid", iss_valid, 1'b0);
        check("full", full, 1'b0);
        report_test("reset");

        set_disp(8'h11, 1'b0, 32'h1234_5678, 1'b0, 32'h9abc_def0);
        advance();
        wait_issue(lat);
        check("ready latency", lat, 2);
        check("iss_pkt.src1_val", iss_pkt.src1_val, 32'h1234_5678);
        report_test("ready");

        set_disp(8'h22, 1'b1, 32'd9, 1'b0, 32'h0000_0042);
        advance();
        repeat (3) advance();
        set_bcast(5'd9, 32'h0bad_f00d);
        advance();
        wait_issue(lat);
        check("pending latency", lat, 2);
        check("iss_pkt.src1_val", iss_pkt.src1_val, 32'h0bad_f00d);
        // Producer broadcasts in the dispatch cycle
        set_disp(8'h23, 1'b0, 32'h0000_0077, 1'b1, 32'd10);
        set_bcast(5'd10, 32'h5eed_0010);
        advance();
        wait_issue(lat);
        check("same-cycle latency", lat, 2);
        check("iss_pkt.src2_val", iss_pkt.src2_val, 32'h5eed_0010);
        report_test("pending");

        first_rob = next_rob;
        for (int i = 0; i < N; i++) begin
            set_disp(8'h40 + 8'(i), 1'b1, 32'd12, 1'b0, 32'h1000 + i);
            advance();
        end
        check("full", full, 1'b1);
        set_bcast(5'd12, 32'hcafe_0012);
        advance();
        check("full", full, 1'b1);
        advance();
        check("full", full, 1'b0);
        report_test("fill");

        // All four woke together, so they leave in entry order
        for (int i = 0; i < N; i++) begin
            check("iss_valid", iss_valid, 1'b1);
            check("iss_pkt.robid", iss_pkt.robid, first_rob + rs_pkg::t_robid'(i));
            advance();
        end
        check("iss_valid", iss_valid, 1'b0);
        report_test("competition");

        for (int c = 0; c < RANDOM_CYC; c++) begin
            rnd = $random(seed);
            if (rnd[1:0] == 2'b00 && outstanding[rnd[12:8]])
                set_bcast(rnd[12:8], $random(seed));
            if (!full && rnd[2]) begin
                for (int s = 0; s < 2; s++)
                    w[s] = $random(seed);
                set_disp(rnd[31:24], rnd[3], w[0], rnd[4], w[1]);
            end
            advance();
        end
        // Wake every producer still owed
        guard = 0;
        while (!model_empty() && guard < DRAIN_CYC) begin
            for (int t = 0; t < 2**`RS_ROBID_W; t++)
                if (outstanding[t] && !ro_valid)
                    set_bcast(rs_pkg::t_robid'(t), $random(seed));
            advance();
            guard++;
        end
        if (!model_empty())
            report_failure("Random run did not drain, entries still waiting");
        check("issue count", issue_cnt, disp_cnt);
        report_test("random");

        $display("checks %0d, errors %0d, dispatched %0d, issued %0d",
                 check_cnt, err_cnt, disp_cnt, issue_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
